/* ctrlUnit_settings.svh */
`ifndef CTRLUNIT_SETTINGS_SVH
`define CTRLUNIT_SETTINGS_SVH

// instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6
`define REG_W 5
`define SHAMT_W 5
`define HALF_W 16
`define STATE_W 5
`define STEP_W 2

`define OP_RTYPE 6'b000000
`define OP_ADDI 6'b001000
`define OP_ADDIU 6'b001001

`define FUNCT_ADD 6'b100000
`define FUNCT_SUB 6'b100010
`define FUNCT_AND 6'b100100
`define FUNCT_SLL 6'b000000
`define FUNCT_SRL 6'b000010
`define FUNCT_SRA 6'b000011
`define FUNCT_MULT 6'b011000
`define FUNCT_DIV 6'b011010
`define FUNCT_MFHI 6'b010000
`define FUNCT_MFLO 6'b010010

// sequencer states
`define ST_INIT 5'd0
`define ST_FETCH 5'd1
`define ST_FETCH_PC 5'd2
`define ST_DECODE 5'd3
`define ST_EXEC_R 5'd4
`define ST_WRITE_R 5'd5
`define ST_EXEC_IMM 5'd6
`define ST_WRITE_IMM 5'd7
`define ST_SHIFT 5'd8
`define ST_MUL_START 5'd9
`define ST_MUL_WAIT 5'd10
`define ST_MUL_RESULT 5'd11
`define ST_DIV_START 5'd12
`define ST_DIV_WAIT 5'd13
`define ST_DIV_RESULT 5'd14
`define ST_MOVE_HILO 5'd15
`define ST_EXCEPTION 5'd16
`define ST_RESET 5'd17 // held while reset is high, all outputs quiet

`define OPK_ALU_R 3'd0
`define OPK_ADD_IMM 3'd1
`define OPK_SHIFT 3'd2
`define OPK_MULT 3'd3
`define OPK_DIV 3'd4
`define OPK_MOVE_HILO 3'd5
`define OPK_NOP 3'd6
`define OPK_ILLEGAL 3'd7

`define FETCH_WAIT 3 // memory read latency in cycles
`define SHIFT_STEPS 3

`define ALU_PASS 3'b000
`define ALU_ADD 3'b001
`define ALU_SUB 3'b010
`define ALU_AND 3'b011

`define SH_NONE 3'b000
`define SH_LOAD 3'b001
`define SH_LEFT 3'b010
`define SH_RIGHT_LOG 3'b011
`define SH_RIGHT_ARITH 3'b100

`define SHN_SHAMT 2'b10

`define SRCA_PC 2'b00
`define SRCA_REG 2'b01
`define SRCB_REG 3'b000
`define SRCB_FOUR 3'b001
`define SRCB_IMM 3'b011

`define PCSRC_ALUOUT 2'b10
`define PCSRC_EXC 2'b11

`define REGDST_RD 2'b00
`define REGDST_SP 2'b01
`define REGDST_RT 2'b11

`define WDATA_ALUOUT 3'b000
`define WDATA_LO 3'b001
`define WDATA_HI 3'b010
`define WDATA_SPINIT 3'b011
`define WDATA_SHIFT 3'b110

`endif

/* ctrlUnitPkg.sv */
`include "ctrlUnit_settings.svh"

package ctrlUnitPkg;

    // lower half of the instruction word
    // R-type fields for the decoder, raw view for the nop test
    typedef union packed {
        struct packed {
            logic [`REG_W-1:0] rd;
            logic [`SHAMT_W-1:0] shamt;
            logic [`FUNCT_W-1:0] funct;
        } rFields;
        logic [`HALF_W-1:0] whole;
    } instrLow_u;

endpackage

/* decodedIf.sv */
`timescale 1ns/10ps
`include "ctrlUnit_settings.svh"

interface decodedIf;
    logic [2:0] opKind;
    logic [2:0] aluOp;
    logic [2:0] shiftOp;
    logic trapOnOverflow; // add, sub, addi only
    logic readHi; // mfhi vs mflo

    modport decoder (
        output opKind,
        output aluOp,
        output shiftOp,
        output trapOnOverflow,
        output readHi
    );

    modport sequencer (
        input opKind,
        input trapOnOverflow
    );

    modport wordGen (
        input aluOp,
        input shiftOp,
        input readHi
    );
endinterface

/* instrDecoder.sv */
`timescale 1ns/10ps
`include "ctrlUnit_settings.svh"

module instrDecoder (
    input logic [`OPCODE_W-1:0] opcode,
    input ctrlUnitPkg::instrLow_u instrLow,
    decodedIf.decoder dec
);

    always_comb begin
        dec.opKind = `OPK_ILLEGAL; // anything not matched below traps
        dec.aluOp = `ALU_PASS;
        dec.shiftOp = `SH_NONE;
        dec.trapOnOverflow = 1'b0;
        dec.readHi = 1'b0;

        case (opcode)
            `OP_RTYPE: begin
                if (instrLow.whole == '0) begin
                    dec.opKind = `OPK_NOP; // all-zero word, not sll
                end else begin
                    case (instrLow.rFields.funct)
                        `FUNCT_ADD: begin
                            dec.opKind = `OPK_ALU_R;
                            dec.aluOp = `ALU_ADD;
                            dec.trapOnOverflow = 1'b1;
                        end
                        `FUNCT_SUB: begin
                            dec.opKind = `OPK_ALU_R;
                            dec.aluOp = `ALU_SUB;
                            dec.trapOnOverflow = 1'b1;
                        end
                        `FUNCT_AND: begin
                            dec.opKind = `OPK_ALU_R;
                            dec.aluOp = `ALU_AND;
                        end
                        `FUNCT_SLL: begin
                            dec.opKind = `OPK_SHIFT;
                            dec.shiftOp = `SH_LEFT;
                        end
                        `FUNCT_SRL: begin
                            dec.opKind = `OPK_SHIFT;
                            dec.shiftOp = `SH_RIGHT_LOG;
                        end
                        `FUNCT_SRA: begin
                            dec.opKind = `OPK_SHIFT;
                            dec.shiftOp = `SH_RIGHT_ARITH;
                        end
                        `FUNCT_MULT: dec.opKind = `OPK_MULT;
                        `FUNCT_DIV: dec.opKind = `OPK_DIV;
                        `FUNCT_MFHI: begin
                            dec.opKind = `OPK_MOVE_HILO;
                            dec.readHi = 1'b1;
                        end
                        `FUNCT_MFLO: dec.opKind = `OPK_MOVE_HILO;
                        default: dec.opKind = `OPK_ILLEGAL;
                    endcase
                end
            end
            `OP_ADDI: begin
                dec.opKind = `OPK_ADD_IMM;
                dec.aluOp = `ALU_ADD;
                dec.trapOnOverflow = 1'b1;
            end
            `OP_ADDIU: begin
                dec.opKind = `OPK_ADD_IMM; // unsigned form, never traps
                dec.aluOp = `ALU_ADD;
            end
            default: dec.opKind = `OPK_ILLEGAL;
        endcase
    end

endmodule

/* mainSequencer.sv */
`timescale 1ns/10ps
`include "ctrlUnit_settings.svh"

module mainSequencer (
    input logic clk,
    input logic reset,
    input logic overflow,
    input logic multEnd,
    input logic divEnd,
    input logic divZero,
    decodedIf.sequencer dec,
    output logic [`STATE_W-1:0] state,
    output logic [`STEP_W-1:0] step
);

    logic [`STATE_W-1:0] stateNext;
    logic [`STEP_W-1:0] stepNext;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= `ST_RESET;
            step <= '0;
        end else begin
            state <= stateNext;
            step <= stepNext;
        end
    end

    always_comb begin
        stateNext = state;
        stepNext = '0; // only FETCH and SHIFT count

        case (state)
            `ST_RESET: stateNext = `ST_INIT;
            `ST_INIT: stateNext = `ST_FETCH; // stack pointer written here

            `ST_FETCH: begin
                if (step == `FETCH_WAIT - 1) begin
                    stateNext = `ST_FETCH_PC;
                end else begin
                    stepNext = step + 2'd1;
                end
            end

            `ST_FETCH_PC: stateNext = `ST_DECODE;

            `ST_DECODE: begin
                case (dec.opKind)
                    `OPK_ALU_R: stateNext = `ST_EXEC_R;
                    `OPK_ADD_IMM: stateNext = `ST_EXEC_IMM;
                    `OPK_SHIFT: stateNext = `ST_SHIFT;
                    `OPK_MULT: stateNext = `ST_MUL_START;
                    `OPK_DIV: stateNext = `ST_DIV_START;
                    `OPK_MOVE_HILO: stateNext = `ST_MOVE_HILO;
                    `OPK_NOP: stateNext = `ST_FETCH;
                    default: stateNext = `ST_EXCEPTION;
                endcase
            end

            // overflow is judged while the result is still in ALUOut
            `ST_EXEC_R: begin
                if (overflow && dec.trapOnOverflow) begin
                    stateNext = `ST_EXCEPTION;
                end else begin
                    stateNext = `ST_WRITE_R;
                end
            end

            `ST_EXEC_IMM: begin
                if (overflow && dec.trapOnOverflow) begin
                    stateNext = `ST_EXCEPTION;
                end else begin
                    stateNext = `ST_WRITE_IMM;
                end
            end

            `ST_WRITE_R,
            `ST_WRITE_IMM: stateNext = `ST_FETCH;

            `ST_SHIFT: begin
                if (step == `SHIFT_STEPS - 1) begin
                    stateNext = `ST_FETCH;
                end else begin
                    stepNext = step + 2'd1;
                end
            end

            `ST_MUL_START: stateNext = `ST_MUL_WAIT;
            `ST_MUL_WAIT: begin
                if (multEnd) begin
                    stateNext = `ST_MUL_RESULT;
                end
            end
            `ST_MUL_RESULT: stateNext = `ST_FETCH;

            `ST_DIV_START: stateNext = `ST_DIV_WAIT;
            `ST_DIV_WAIT: begin
                if (divZero) begin
                    stateNext = `ST_FETCH; // abort, HI/LO untouched
                end else if (divEnd) begin
                    stateNext = `ST_DIV_RESULT;
                end
            end
            `ST_DIV_RESULT: stateNext = `ST_FETCH;

            `ST_MOVE_HILO,
            `ST_EXCEPTION: stateNext = `ST_FETCH;

            default: stateNext = `ST_FETCH;
        endcase
    end

endmodule

/* ctrlWordGen.sv */
`timescale 1ns/10ps
`include "ctrlUnit_settings.svh"

module ctrlWordGen (
    input logic [`STATE_W-1:0] state,
    input logic [`STEP_W-1:0] step,
    decodedIf.wordGen dec,
    output logic writePc,
    output logic writeA,
    output logic writeB,
    output logic writeAluOut,
    output logic writeInstruction,
    output logic writeReg,
    output logic writeHilo,
    output logic multCtrl,
    output logic divCtrl,
    output logic hiloCtrl,
    output logic [1:0] shiftNCtrl,
    output logic [2:0] shiftCtrl,
    output logic [1:0] aluSrcACtrl,
    output logic [2:0] aluSrcBCtrl,
    output logic [1:0] pcSrcCtrl,
    output logic [1:0] writeRegCtrl,
    output logic [2:0] writeDataCtrl,
    output logic [2:0] aluCtrl
);

    always_comb begin
        writePc = 1'b0;
        writeA = 1'b0;
        writeB = 1'b0;
        writeAluOut = 1'b0;
        writeInstruction = 1'b0;
        writeReg = 1'b0;
        writeHilo = 1'b0;
        multCtrl = 1'b0;
        divCtrl = 1'b0;
        hiloCtrl = 1'b0;
        shiftNCtrl = 2'b00;
        shiftCtrl = `SH_NONE;
        aluSrcACtrl = `SRCA_PC;
        aluSrcBCtrl = `SRCB_REG;
        pcSrcCtrl = 2'b00;
        writeRegCtrl = `REGDST_RD;
        writeDataCtrl = `WDATA_ALUOUT;
        aluCtrl = `ALU_PASS;

        case (state)
            `ST_INIT: begin
                writeReg = 1'b1;
                writeRegCtrl = `REGDST_SP;
                writeDataCtrl = `WDATA_SPINIT;
            end
            `ST_FETCH: begin
                writeInstruction = 1'b1;
                writeAluOut = 1'b1; // PC + 4 into ALUOut
                aluSrcACtrl = `SRCA_PC;
                aluSrcBCtrl = `SRCB_FOUR;
                aluCtrl = `ALU_ADD;
            end
            `ST_FETCH_PC: begin
                writePc = 1'b1;
                pcSrcCtrl = `PCSRC_ALUOUT;
            end
            `ST_DECODE: begin
                writeA = 1'b1;
                writeB = 1'b1;
            end
            `ST_EXEC_R: begin
                writeAluOut = 1'b1;
                aluSrcACtrl = `SRCA_REG;
                aluSrcBCtrl = `SRCB_REG;
                aluCtrl = dec.aluOp;
            end
            `ST_EXEC_IMM: begin
                writeAluOut = 1'b1;
                aluSrcACtrl = `SRCA_REG; // rs + immediate
                aluSrcBCtrl = `SRCB_IMM;
                aluCtrl = `ALU_ADD;
            end
            `ST_WRITE_R: begin
                writeReg = 1'b1;
                writeRegCtrl = `REGDST_RD;
                writeDataCtrl = `WDATA_ALUOUT;
            end
            `ST_WRITE_IMM: begin
                writeReg = 1'b1;
                writeRegCtrl = `REGDST_RT;
                writeDataCtrl = `WDATA_ALUOUT;
            end
            `ST_SHIFT: begin
                shiftNCtrl = `SHN_SHAMT;
                if (step == 2'd0) begin
                    shiftCtrl = `SH_LOAD;
                end else begin
                    shiftCtrl = dec.shiftOp;
                end
                // last step writes the shifter output back
                if (step == `SHIFT_STEPS - 1) begin
                    writeReg = 1'b1;
                    writeRegCtrl = `REGDST_RD;
                    writeDataCtrl = `WDATA_SHIFT;
                end
            end
            `ST_MUL_START: multCtrl = 1'b1;
            `ST_DIV_START: divCtrl = 1'b1;
            `ST_MUL_RESULT: begin
                writeHilo = 1'b1;
                hiloCtrl = 1'b0; // multiplier result
            end
            `ST_DIV_RESULT: begin
                writeHilo = 1'b1;
                hiloCtrl = 1'b1;
            end
            `ST_MOVE_HILO: begin
                writeReg = 1'b1;
                writeRegCtrl = `REGDST_RD;
                writeDataCtrl = dec.readHi ? `WDATA_HI : `WDATA_LO;
            end
            `ST_EXCEPTION: begin
                writePc = 1'b1;
                pcSrcCtrl = `PCSRC_EXC;
            end
            default: begin
                // wait states and reset keep the all-zero word
            end
        endcase
    end

endmodule

/* ctrlUnit.sv */
`timescale 1ns/10ps
`include "ctrlUnit_settings.svh"

module ctrlUnit (
    input logic clk,
    input logic reset,
    input logic [`OPCODE_W-1:0] opcode,
    input logic [`HALF_W-1:0] instrLow,
    input logic overflow,
    input logic multEnd,
    input logic divEnd,
    input logic divZero,
    output logic writePc,
    output logic writeA,
    output logic writeB,
    output logic writeAluOut,
    output logic writeInstruction,
    output logic writeReg,
    output logic writeHilo,
    output logic multCtrl,
    output logic divCtrl,
    output logic hiloCtrl,
    output logic [1:0] shiftNCtrl,
    output logic [2:0] shiftCtrl,
    output logic [1:0] aluSrcACtrl,
    output logic [2:0] aluSrcBCtrl,
    output logic [1:0] pcSrcCtrl,
    output logic [1:0] writeRegCtrl,
    output logic [2:0] writeDataCtrl,
    output logic [2:0] aluCtrl
);
    import ctrlUnitPkg::*;

    instrLow_u instrLowU;
    logic [`STATE_W-1:0] state;
    logic [`STEP_W-1:0] step;

    decodedIf decBus ();

    assign instrLowU = instrLow_u'(instrLow);

    instrDecoder uDecoder (
        .opcode(opcode),
        .instrLow(instrLowU),
        .dec(decBus.decoder)
    );

    mainSequencer uSequencer (
        .clk(clk),
        .reset(reset),
        .overflow(overflow),
        .multEnd(multEnd),
        .divEnd(divEnd),
        .divZero(divZero),
        .dec(decBus.sequencer),
        .state(state),
        .step(step)
    );

    ctrlWordGen uWordGen (
        .state(state),
        .step(step),
        .dec(decBus.wordGen),
        .writePc(writePc),
        .writeA(writeA),
        .writeB(writeB),
        .writeAluOut(writeAluOut),
        .writeInstruction(writeInstruction),
        .writeReg(writeReg),
        .writeHilo(writeHilo),
        .multCtrl(multCtrl),
        .divCtrl(divCtrl),
        .hiloCtrl(hiloCtrl),
        .shiftNCtrl(shiftNCtrl),
        .shiftCtrl(shiftCtrl),
        .aluSrcACtrl(aluSrcACtrl),
        .aluSrcBCtrl(aluSrcBCtrl),
        .pcSrcCtrl(pcSrcCtrl),
        .writeRegCtrl(writeRegCtrl),
        .writeDataCtrl(writeDataCtrl),
        .aluCtrl(aluCtrl)
    );

endmodule

/* ctrlUnitModel.svh */
`ifndef CTRLUNITMODEL_SVH
`define CTRLUNITMODEL_SVH

typedef struct packed {
    logic writePc;
    logic writeA;
    logic writeB;
    logic writeAluOut;
    logic writeInstruction;
    logic writeReg;
    logic writeHilo;
    logic multCtrl;
    logic divCtrl;
    logic hiloCtrl;
    logic [1:0] shiftNCtrl;
    logic [2:0] shiftCtrl;
    logic [1:0] aluSrcACtrl;
    logic [2:0] aluSrcBCtrl;
    logic [1:0] pcSrcCtrl;
    logic [1:0] writeRegCtrl;
    logic [2:0] writeDataCtrl;
    logic [2:0] aluCtrl;
} ctrlWord_t;

// instruction kinds as the stimulus picks them
localparam int kindAdd = 0;
localparam int kindSub = 1;
localparam int kindAnd = 2;
localparam int kindAddi = 3;
localparam int kindAddiu = 4;
localparam int kindSll = 5;
localparam int kindSrl = 6;
localparam int kindSra = 7;
localparam int kindMult = 8;
localparam int kindDiv = 9;
localparam int kindMfhi = 10;
localparam int kindMflo = 11;
localparam int kindNop = 12;
localparam int kindIllegal = 13;

logic modelInReset;
logic [`STATE_W-1:0] modelState;
int modelStep;
int modelKind;

function automatic ctrlWord_t predictWord();
    ctrlWord_t w;
    w = '0;
    if (!modelInReset) begin
        case (modelState)
            `ST_INIT: begin
                w.writeReg = 1'b1;
                w.writeRegCtrl = `REGDST_SP;
                w.writeDataCtrl = `WDATA_SPINIT;
            end
            `ST_FETCH: begin
                w.writeInstruction = 1'b1;
                w.writeAluOut = 1'b1;
                w.aluSrcBCtrl = `SRCB_FOUR;
                w.aluCtrl = `ALU_ADD;
            end
            `ST_FETCH_PC: begin
                w.writePc = 1'b1;
                w.pcSrcCtrl = `PCSRC_ALUOUT;
            end
            `ST_DECODE: begin
                w.writeA = 1'b1;
                w.writeB = 1'b1;
            end
            `ST_EXEC_R: begin
                w.writeAluOut = 1'b1;
                w.aluSrcACtrl = `SRCA_REG;
                w.aluSrcBCtrl = `SRCB_REG;
                if (modelKind == kindAdd) w.aluCtrl = `ALU_ADD;
                else if (modelKind == kindSub) w.aluCtrl = `ALU_SUB;
                else w.aluCtrl = `ALU_AND;
            end
            `ST_EXEC_IMM: begin
                w.writeAluOut = 1'b1;
                w.aluSrcACtrl = `SRCA_REG;
                w.aluSrcBCtrl = `SRCB_IMM;
                w.aluCtrl = `ALU_ADD;
            end
            `ST_WRITE_R: w.writeReg = 1'b1; // rd, ALUOut
            `ST_WRITE_IMM: begin
                w.writeReg = 1'b1;
                w.writeRegCtrl = `REGDST_RT;
            end
            `ST_SHIFT: begin
                w.shiftNCtrl = `SHN_SHAMT;
                if (modelStep == 0) w.shiftCtrl = `SH_LOAD;
                else if (modelKind == kindSll) w.shiftCtrl = `SH_LEFT;
                else if (modelKind == kindSrl) w.shiftCtrl = `SH_RIGHT_LOG;
                else w.shiftCtrl = `SH_RIGHT_ARITH;
                if (modelStep == `SHIFT_STEPS - 1) begin
                    w.writeReg = 1'b1;
                    w.writeDataCtrl = `WDATA_SHIFT;
                end
            end
            `ST_MUL_START: w.multCtrl = 1'b1;
            `ST_DIV_START: w.divCtrl = 1'b1;
            `ST_MUL_RESULT: w.writeHilo = 1'b1;
            `ST_DIV_RESULT: begin
                w.writeHilo = 1'b1;
                w.hiloCtrl = 1'b1;
            end
            `ST_MOVE_HILO: begin
                w.writeReg = 1'b1;
                w.writeDataCtrl = (modelKind == kindMfhi) ? `WDATA_HI : `WDATA_LO;
            end
            `ST_EXCEPTION: begin
                w.writePc = 1'b1;
                w.pcSrcCtrl = `PCSRC_EXC;
            end
            default: w = '0;
        endcase
    end
    return w;
endfunction

// one clock edge ahead, from the inputs driven for that edge
task automatic advanceModel(input logic resetIn, input logic ovf, input logic mulDone,
                            input logic divDone, input logic divByZeroIn);
    logic [`STATE_W-1:0] nextState;
    int nextStep;
    logic traps;
    nextState = `ST_FETCH;
    nextStep = 0;
    traps = (modelKind == kindAdd) || (modelKind == kindSub) || (modelKind == kindAddi);
    if (resetIn) begin
        modelInReset = 1'b1;
        modelStep = 0;
    end else if (modelInReset) begin
        modelInReset = 1'b0;
        modelState = `ST_INIT;
        modelStep = 0;
    end else begin
        case (modelState)
            `ST_FETCH: begin
                if (modelStep == `FETCH_WAIT - 1) begin
                    nextState = `ST_FETCH_PC;
                end else begin
                    nextState = `ST_FETCH;
                    nextStep = modelStep + 1;
                end
            end
            `ST_FETCH_PC: nextState = `ST_DECODE;
            `ST_DECODE: begin
                case (modelKind)
                    kindAdd, kindSub, kindAnd: nextState = `ST_EXEC_R;
                    kindAddi, kindAddiu: nextState = `ST_EXEC_IMM;
                    kindSll, kindSrl, kindSra: nextState = `ST_SHIFT;
                    kindMult: nextState = `ST_MUL_START;
                    kindDiv: nextState = `ST_DIV_START;
                    kindMfhi, kindMflo: nextState = `ST_MOVE_HILO;
                    kindNop: nextState = `ST_FETCH;
                    default: nextState = `ST_EXCEPTION;
                endcase
            end
            `ST_EXEC_R: nextState = (ovf && traps) ? `ST_EXCEPTION : `ST_WRITE_R;
            `ST_EXEC_IMM: nextState = (ovf && traps) ? `ST_EXCEPTION : `ST_WRITE_IMM;
            `ST_SHIFT: begin
                if (modelStep != `SHIFT_STEPS - 1) begin
                    nextState = `ST_SHIFT;
                    nextStep = modelStep + 1;
                end
            end
            `ST_MUL_START: nextState = `ST_MUL_WAIT;
            `ST_MUL_WAIT: nextState = mulDone ? `ST_MUL_RESULT : `ST_MUL_WAIT;
            `ST_DIV_START: nextState = `ST_DIV_WAIT;
            `ST_DIV_WAIT: begin
                if (divByZeroIn) nextState = `ST_FETCH; // abort wins over done
                else if (divDone) nextState = `ST_DIV_RESULT;
                else nextState = `ST_DIV_WAIT;
            end
            default: nextState = `ST_FETCH;
        endcase
        modelState = nextState;
        modelStep = nextStep;
    end
endtask

`endif

/* ctrlUnitTb.sv */
`timescale 1ns/10ps
`include "ctrlUnit_settings.svh"

module ctrlUnitTb;
    localparam int resetCycles = 16;
    localparam int numInstr = 400;
    localparam int cycleLimit = numInstr * 20 + resetCycles;

    logic clk;
    logic reset;
    logic [`OPCODE_W-1:0] opcode;
    logic [`HALF_W-1:0] instrLow;
    logic overflow;
    logic multEnd;
    logic divEnd;
    logic divZero;
    logic writePc, writeA, writeB, writeAluOut, writeInstruction, writeReg, writeHilo;
    logic multCtrl, divCtrl, hiloCtrl;
    logic [1:0] shiftNCtrl, aluSrcACtrl, pcSrcCtrl, writeRegCtrl;
    logic [2:0] shiftCtrl, aluSrcBCtrl, writeDataCtrl, aluCtrl;

    `include "ctrlUnitModel.svh"

    int cycle = 0;
    int issued = 0;
    int mulLeft = 0;
    int divLeft = 0;
    logic divByZero = 1'b0;
    string testName = "reset";
    int testErrors = 0;
    int passCount = 0;
    int failCount = 0;
    int mismatchTotal = 0;
    logic runDone = 1'b0;
    logic timedOut = 1'b0;

    ctrlUnit u_dut (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic string kindName(input int kind);
        case (kind)
            kindAdd: return "add";
            kindSub: return "sub";
            kindAnd: return "and";
            kindAddi: return "addi";
            kindAddiu: return "addiu";
            kindSll: return "sll";
            kindSrl: return "srl";
            kindSra: return "sra";
            kindMult: return "mult";
            kindDiv: return "div";
            kindMfhi: return "mfhi";
            kindMflo: return "mflo";
            kindNop: return "nop";
            default: return "illegal";
        endcase
    endfunction

    function automatic logic isKnownFunct(input logic [`FUNCT_W-1:0] f);
        case (f)
            `FUNCT_ADD, `FUNCT_SUB, `FUNCT_AND, `FUNCT_SLL, `FUNCT_SRL, `FUNCT_SRA,
            `FUNCT_MULT, `FUNCT_DIV, `FUNCT_MFHI, `FUNCT_MFLO: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic compareField(input string field, input logic [2:0] expected,
                                input logic [2:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s cycle %0d %s: expected %0d actual %0d",
                     testName, cycle, field, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkOutputs();
        ctrlWord_t e;
        e = predictWord();
        compareField("writePc", e.writePc, writePc);
        compareField("writeA", e.writeA, writeA);
        compareField("writeB", e.writeB, writeB);
        compareField("writeAluOut", e.writeAluOut, writeAluOut);
        compareField("writeInstruction", e.writeInstruction, writeInstruction);
        compareField("writeReg", e.writeReg, writeReg);
        compareField("writeHilo", e.writeHilo, writeHilo);
        compareField("multCtrl", e.multCtrl, multCtrl);
        compareField("divCtrl", e.divCtrl, divCtrl);
        compareField("hiloCtrl", e.hiloCtrl, hiloCtrl);
        compareField("shiftNCtrl", e.shiftNCtrl, shiftNCtrl);
        compareField("shiftCtrl", e.shiftCtrl, shiftCtrl);
        compareField("aluSrcACtrl", e.aluSrcACtrl, aluSrcACtrl);
        compareField("aluSrcBCtrl", e.aluSrcBCtrl, aluSrcBCtrl);
        compareField("pcSrcCtrl", e.pcSrcCtrl, pcSrcCtrl);
        compareField("writeRegCtrl", e.writeRegCtrl, writeRegCtrl);
        compareField("writeDataCtrl", e.writeDataCtrl, writeDataCtrl);
        compareField("aluCtrl", e.aluCtrl, aluCtrl);
    endtask

    task automatic closeTest();
        mismatchTotal += testErrors;
        if (testErrors == 0) begin
            passCount++;
            $display("test %s: ok", testName);
        end else begin
            failCount++;
            $display("test %s: failed with %0d mismatches", testName, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic issueInstr(input int kind);
        logic [`REG_W-1:0] rd;
        logic [`SHAMT_W-1:0] shamt;
        logic [`FUNCT_W-1:0] funct;
        rd = $urandom_range(1, 31); // nonzero keeps sll apart from nop
        shamt = $urandom;
        case (kind)
            kindSub: funct = `FUNCT_SUB;
            kindAnd: funct = `FUNCT_AND;
            kindSll: funct = `FUNCT_SLL;
            kindSrl: funct = `FUNCT_SRL;
            kindSra: funct = `FUNCT_SRA;
            kindMult: funct = `FUNCT_MULT;
            kindDiv: funct = `FUNCT_DIV;
            kindMfhi: funct = `FUNCT_MFHI;
            kindMflo: funct = `FUNCT_MFLO;
            default: funct = `FUNCT_ADD;
        endcase
        opcode = `OP_RTYPE;
        instrLow = {rd, shamt, funct};
        if (kind == kindAddi || kind == kindAddiu) begin
            opcode = (kind == kindAddi) ? `OP_ADDI : `OP_ADDIU;
            instrLow = $urandom;
        end else if (kind == kindNop) begin
            instrLow = '0;
        end else if (kind == kindIllegal) begin
            if ($urandom_range(0, 1) == 1) begin
                opcode = $urandom;
                while (opcode == `OP_RTYPE || opcode == `OP_ADDI || opcode == `OP_ADDIU) begin
                    opcode = $urandom;
                end
                instrLow = $urandom;
            end else begin
                funct = $urandom;
                while (isKnownFunct(funct)) begin
                    funct = $urandom;
                end
                instrLow = {rd, shamt, funct};
            end
        end
        modelKind = kind;
    endtask

    // multiply and divide units, started by the one-cycle pulses
    task automatic playUnits();
        multEnd = 1'b0;
        divEnd = 1'b0;
        divZero = 1'b0;
        if (multCtrl === 1'b1) begin
            mulLeft = $urandom_range(1, 8);
        end else if (mulLeft > 0) begin
            mulLeft--;
            if (mulLeft == 0) multEnd = 1'b1;
        end
        if (divCtrl === 1'b1) begin
            divLeft = $urandom_range(1, 8);
            divByZero = ($urandom_range(0, 4) == 0);
        end else if (divLeft > 0) begin
            divLeft--;
            if (divLeft == 0) begin
                divEnd = 1'b1; // raised with divZero too, abort must win
                divZero = divByZero;
            end
        end
    endtask

    initial begin
        int seedInit;
        int pick;
        seedInit = $urandom(68116);
        reset = 1'b1;
        opcode = '0;
        instrLow = '0;
        overflow = 1'b0;
        multEnd = 1'b0;
        divEnd = 1'b0;
        divZero = 1'b0;
        modelInReset = 1'b1;
        modelState = `ST_INIT;
        modelStep = 0;
        modelKind = kindNop;

        while (!runDone) begin
            @(negedge clk);
            cycle++;
            checkOutputs();
            if (cycle == resetCycles) reset = 1'b0;
            if (!modelInReset && modelState == `ST_FETCH && modelStep == 0) begin
                closeTest();
                if (issued < numInstr) begin
                    pick = $urandom_range(0, 15);
                    if (pick == 14) pick = kindIllegal;
                    else if (pick == 15) pick = kindAdd;
                    issueInstr(pick);
                    issued++;
                    testName = $sformatf("instr %0d %s", issued, kindName(pick));
                end else begin
                    runDone = 1'b1;
                end
            end
            if (!runDone) begin
                playUnits();
                overflow = $urandom_range(0, 1);
                advanceModel(reset, overflow, multEnd, divEnd, divZero);
                if (cycle >= cycleLimit) begin
                    $display("run did not finish within %0d cycles, test %s left open",
                             cycleLimit, testName);
                    failCount++;
                    timedOut = 1'b1;
                    runDone = 1'b1;
                end
            end
        end

        $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                 passCount + failCount, passCount, failCount, mismatchTotal);
        if (failCount == 0 && !timedOut) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+.
ctrlUnitPkg.sv
decodedIf.sv
instrDecoder.sv
mainSequencer.sv
ctrlWordGen.sv
ctrlUnit.sv
ctrlUnitTb.sv
